//--- rtl/sched_cfg_pkg.sv
// scheduler queue structure
// queue counts and depths, write watermarks and derived index widths
`default_nettype none

package sched_cfg_pkg;

    localparam int NUM_RD   = 4;                      // read queues take indices 0..NUM_RD-1
    localparam int NUM_WR   = 3;                      // write queues follow the read queues
    localparam int NUM_Q    = NUM_RD + NUM_WR;        // total queue count
    localparam int DEPTH_RD = 4;                      // entries per read queue
    localparam int DEPTH_WR = 2;                      // entries per write queue

    localparam int Q_IDX_W  = $clog2(NUM_Q);                 // queue index width
    localparam int WR_CNT_W = $clog2(NUM_WR * DEPTH_WR + 1); // holds 0..total write slots

    typedef logic [Q_IDX_W-1:0]  q_idx_t;             // absolute or per-kind queue index
    typedef logic [NUM_Q-1:0]    q_mask_t;            // one bit per queue
    typedef logic [WR_CNT_W-1:0] wr_cnt_t;            // pending write count

    localparam wr_cnt_t HIGH_WM = wr_cnt_t'(5);       // write drain starts here
    localparam wr_cnt_t LOW_WM  = wr_cnt_t'(2);       // write drain stops once at or below

    // kind masks over the queue vector
    localparam q_mask_t RD_MASK = q_mask_t'((1 << NUM_RD) - 1);
    localparam q_mask_t WR_MASK = ~RD_MASK;

endpackage

`default_nettype wire

//--- rtl/sched_req_pkg.sv
// memory request record
// field layout of a scheduled request and the request kind encoding
`default_nettype none

package sched_req_pkg;

    localparam int ROW_W   = 4;                       // dram row bits
    localparam int BURST_W = 3;                       // column group used for burst matching
    localparam int COL_W   = 8;                       // column bits

    localparam logic KIND_RD = 1'b0;                  // is_write value of a read
    localparam logic KIND_WR = 1'b1;                  // is_write value of a write

    typedef struct packed {
        logic               is_write;                 // request kind
        logic [ROW_W-1:0]   row;                      // target row
        logic [BURST_W-1:0] burst;                    // column group
        logic [COL_W-1:0]   col;                      // column inside the group
    } req_t;

    localparam int REQ_W = $bits(req_t);              // flat request width

endpackage

`default_nettype wire

//--- rtl/bank_if.sv
// queue bank bus
// push and pop enables, per-queue status and head entries between the bank blocks
`timescale 1ns/1ns
`default_nettype none

interface bank_if;

    sched_cfg_pkg::q_mask_t  wr_en;                   // one-hot push from the placer
    sched_cfg_pkg::q_mask_t  rd_en;                   // one-hot pop from the controller
    sched_req_pkg::req_t     wr_req;                  // entry written on push

    sched_cfg_pkg::q_mask_t  full;                    // per queue full flag
    sched_cfg_pkg::q_mask_t  empty;                   // per queue empty flag
    logic [sched_cfg_pkg::NUM_Q-1:0][sched_req_pkg::ROW_W-1:0] last_row; // newest row per queue
    sched_req_pkg::req_t [sched_cfg_pkg::NUM_Q-1:0] head; // oldest entry per queue
    sched_cfg_pkg::wr_cnt_t  wr_pending;              // writes stored over all write queues

    modport bank (
        input  wr_en, rd_en, wr_req,
        output full, empty, last_row, head, wr_pending
    );

    modport place (
        output wr_en,
        input  full, empty, last_row
    );

    modport ctrl (
        output rd_en,
        input  empty, head, wr_pending
    );

    modport top (
        output wr_req
    );

endinterface

`default_nettype wire

//--- rtl/req_array.sv
// request queue
// circular buffer of requests exposing its head and the row of its newest entry
`timescale 1ns/1ns
`default_nettype none

module req_array #(
    parameter int DEPTH = 4                           // power of two not required
) (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire                                 push_i,
    input  wire                                 pop_i,
    input  wire  sched_req_pkg::req_t           data_i,
    output logic                                full_o,
    output logic                                empty_o,
    output sched_req_pkg::req_t                 head_o,
    output logic [sched_req_pkg::ROW_W-1:0]     last_row_o
);

    sched_req_pkg::req_t                mem_q [DEPTH];   // entry storage
    logic [$clog2(DEPTH)-1:0]           wr_ptr_q;        // next slot to write
    logic [$clog2(DEPTH)-1:0]           rd_ptr_q;        // oldest slot
    logic [$clog2(DEPTH+1)-1:0]         count_q;         // stored entries
    logic [sched_req_pkg::ROW_W-1:0]    last_row_q;      // row of the latest push
    logic                               do_push;
    logic                               do_pop;

    assign full_o  = (int'(count_q) == DEPTH);
    assign empty_o = (count_q == '0);
    assign do_push = push_i && !full_o;               // overflow is dropped
    assign do_pop  = pop_i && !empty_o;               // underflow is dropped

    assign head_o     = mem_q[rd_ptr_q];
    assign last_row_o = last_row_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (int'(wr_ptr_q) == DEPTH - 1) ? '0 : wr_ptr_q + 1'b1; // wrap
            end
            if (do_pop) begin
                rd_ptr_q <= (int'(rd_ptr_q) == DEPTH - 1) ? '0 : rd_ptr_q + 1'b1; // wrap
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;  // idle or push and pop together
            endcase
        end
    end

    // payload path
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
            last_row_q      <= data_i.row;           // tracked for row hits on placement
        end
    end

endmodule

`default_nettype wire

//--- rtl/queue_bank.sv
// queue bank
// read and write request queues plus the pending write counter
`timescale 1ns/1ns
`default_nettype none

module queue_bank (
    input wire    clk,
    input wire    rst_n,
    bank_if.bank  bank
);

    logic wr_push;                                    // a write queue takes an entry
    logic wr_pop;                                     // a write queue loses an entry

    // read queues at the low indices
    for (genvar g = 0; g < sched_cfg_pkg::NUM_RD; g++) begin : g_rd
        req_array #(
            .DEPTH (sched_cfg_pkg::DEPTH_RD)
        ) rd_q_inst (
            .clk        (clk),
            .rst_n      (rst_n),
            .push_i     (bank.wr_en[g]),
            .pop_i      (bank.rd_en[g]),
            .data_i     (bank.wr_req),
            .full_o     (bank.full[g]),
            .empty_o    (bank.empty[g]),
            .head_o     (bank.head[g]),
            .last_row_o (bank.last_row[g])
        );
    end

    // write queues above them
    for (genvar g = sched_cfg_pkg::NUM_RD; g < sched_cfg_pkg::NUM_Q; g++) begin : g_wr
        req_array #(
            .DEPTH (sched_cfg_pkg::DEPTH_WR)
        ) wr_q_inst (
            .clk        (clk),
            .rst_n      (rst_n),
            .push_i     (bank.wr_en[g]),
            .pop_i      (bank.rd_en[g]),
            .data_i     (bank.wr_req),
            .full_o     (bank.full[g]),
            .empty_o    (bank.empty[g]),
            .head_o     (bank.head[g]),
            .last_row_o (bank.last_row[g])
        );
    end

    assign wr_push = |(bank.wr_en & sched_cfg_pkg::WR_MASK);
    assign wr_pop  = |(bank.rd_en & sched_cfg_pkg::WR_MASK);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bank.wr_pending <= '0;
        end else begin
            case ({wr_push, wr_pop})
                2'b10:   bank.wr_pending <= bank.wr_pending + 1'b1;
                2'b01:   bank.wr_pending <= bank.wr_pending - 1'b1;
                default: bank.wr_pending <= bank.wr_pending; // both cancel out
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/req_place.sv
// request placer
// picks a queue of the request's kind (row hit, then empty, then not full) and grants
`timescale 1ns/1ns
`default_nettype none

module req_place (
    input  wire                        req_valid_i,
    input  wire  sched_req_pkg::req_t  req_i,
    output logic                       grant_o,
    bank_if.place                      bank
);

    sched_cfg_pkg::q_mask_t kind_mask;                // queues of the request's kind
    sched_cfg_pkg::q_mask_t row_hit;                  // open queue whose newest row matches
    sched_cfg_pkg::q_mask_t empty_q;                  // empty queues of the kind
    sched_cfg_pkg::q_mask_t open_q;                   // queues with a free slot
    sched_cfg_pkg::q_mask_t cand;                     // candidates of the winning rule

    always_comb begin
        kind_mask = (req_i.is_write == sched_req_pkg::KIND_WR) ? sched_cfg_pkg::WR_MASK
                                                               : sched_cfg_pkg::RD_MASK;
        for (int i = 0; i < sched_cfg_pkg::NUM_Q; i++) begin
            row_hit[i] = kind_mask[i] && !bank.full[i] && !bank.empty[i]
                         && (bank.last_row[i] == req_i.row);
        end
        empty_q = bank.empty & kind_mask;
        open_q  = ~bank.full & kind_mask;             // zero when the whole kind is full

        if (|row_hit) begin
            cand = row_hit;
        end else if (|empty_q) begin
            cand = empty_q;
        end else begin
            cand = open_q;
        end
    end

    // isolate the lowest set bit so the lowest index wins
    assign bank.wr_en = req_valid_i ? (cand & (~cand + 1'b1)) : '0;
    assign grant_o    = |bank.wr_en;                  // stored at the coming edge

endmodule

`default_nettype wire

//--- rtl/drain_ctrl.sv
// drain controller
// read-first FSM with watermark write drain, round-robin start and same-burst chaining
`timescale 1ns/1ns
`default_nettype none

module drain_ctrl (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        issue_ready_i,
    output logic                       bus_req_o,
    output logic                       issue_valid_o,
    output sched_req_pkg::req_t        issue_req_o,
    bank_if.ctrl                       bank
);

    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        BURST
    } state_t;

    state_t                              state_q, state_d;
    logic                                wr_mode_q, wr_mode_d;  // write drain mode flag
    sched_cfg_pkg::q_idx_t               rd_ptr_q;              // next read queue to try
    sched_cfg_pkg::q_idx_t               wr_ptr_q;              // next write queue, per kind
    logic [sched_req_pkg::ROW_W-1:0]     burst_row_q;           // row of last issue
    logic [sched_req_pkg::BURST_W-1:0]   burst_grp_q;           // burst field of last issue
    sched_cfg_pkg::q_mask_t              not_empty;
    sched_cfg_pkg::q_mask_t              kind_mask;
    sched_cfg_pkg::q_mask_t              burst_hit;
    logic                                any_pending;
    logic                                rd_pending;
    logic                                burst_found;
    sched_cfg_pkg::q_idx_t               rr_idx;                // round-robin pick
    sched_cfg_pkg::q_idx_t               burst_idx;             // lowest burst hit
    sched_cfg_pkg::q_idx_t               pop_idx;
    logic                                pop;
    sched_req_pkg::req_t                 pop_req;

    // first non-empty queue of a kind, searching from start and wrapping inside the kind
    function automatic sched_cfg_pkg::q_idx_t rr_first(
        input sched_cfg_pkg::q_mask_t ne,
        input sched_cfg_pkg::q_idx_t  start,
        input int                     base,
        input int                     cnt
    );
        sched_cfg_pkg::q_idx_t pick;
        int                    rel;
        pick = sched_cfg_pkg::q_idx_t'(base + int'(start));
        for (int k = cnt - 1; k >= 0; k--) begin
            rel = (int'(start) + k) % cnt;
            if (ne[base + rel]) begin
                pick = sched_cfg_pkg::q_idx_t'(base + rel); // smallest offset wins
            end
        end
        return pick;
    endfunction

    function automatic sched_cfg_pkg::q_idx_t lowest_idx(input sched_cfg_pkg::q_mask_t m);
        sched_cfg_pkg::q_idx_t idx;
        idx = '0;
        for (int i = sched_cfg_pkg::NUM_Q - 1; i >= 0; i--) begin
            if (m[i]) begin
                idx = sched_cfg_pkg::q_idx_t'(i);
            end
        end
        return idx;
    endfunction

    assign not_empty   = ~bank.empty;
    assign any_pending = |not_empty;
    assign rd_pending  = |(not_empty & sched_cfg_pkg::RD_MASK);
    assign kind_mask   = wr_mode_q ? sched_cfg_pkg::WR_MASK : sched_cfg_pkg::RD_MASK;

    // heads matching the last issued row and burst, same kind only
    always_comb begin
        for (int i = 0; i < sched_cfg_pkg::NUM_Q; i++) begin
            burst_hit[i] = kind_mask[i] && not_empty[i]
                           && (bank.head[i].row == burst_row_q)
                           && (bank.head[i].burst == burst_grp_q);
        end
    end

    assign burst_found = (state_q == BURST) && (|burst_hit);
    assign burst_idx   = lowest_idx(burst_hit);
    assign rr_idx      = wr_mode_q
        ? rr_first(not_empty, wr_ptr_q, sched_cfg_pkg::NUM_RD, sched_cfg_pkg::NUM_WR)
        : rr_first(not_empty, rd_ptr_q, 0, sched_cfg_pkg::NUM_RD);

    always_comb begin
        state_d   = state_q;
        wr_mode_d = wr_mode_q;
        pop       = 1'b0;
        pop_idx   = burst_idx;
        case (state_q)
            IDLE: begin
                if (any_pending) begin
                    state_d   = REQUEST;
                    // enter at high watermark or with no reads, leave only at low watermark
                    wr_mode_d = (bank.wr_pending >= sched_cfg_pkg::HIGH_WM) || !rd_pending
                                || (wr_mode_q && bank.wr_pending > sched_cfg_pkg::LOW_WM);
                end
            end
            REQUEST: begin
                if (issue_ready_i) begin              // bus granted by the arbiter
                    pop     = 1'b1;
                    pop_idx = rr_idx;
                    state_d = BURST;
                end
            end
            BURST: begin
                if (burst_found) begin
                    pop = 1'b1;                       // chain without asking again
                end else begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    assign bus_req_o  = (state_q == REQUEST) || burst_found;
    assign bank.rd_en = pop ? (sched_cfg_pkg::q_mask_t'(1) << pop_idx) : '0;
    assign pop_req    = bank.head[pop_idx];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q       <= IDLE;
            wr_mode_q     <= 1'b0;
            rd_ptr_q      <= '0;
            wr_ptr_q      <= '0;
            issue_valid_o <= 1'b0;
            issue_req_o   <= '0;
        end else begin
            state_q       <= state_d;
            wr_mode_q     <= wr_mode_d;
            issue_valid_o <= pop;                     // one cycle per pop
            if (pop) begin
                issue_req_o <= pop_req;
                if (wr_mode_q) begin                  // next start is after the drained queue
                    wr_ptr_q <= (pop_idx == sched_cfg_pkg::q_idx_t'(sched_cfg_pkg::NUM_Q - 1))
                        ? '0
                        : pop_idx - sched_cfg_pkg::q_idx_t'(sched_cfg_pkg::NUM_RD) + 1'b1;
                end else begin
                    rd_ptr_q <= (pop_idx == sched_cfg_pkg::q_idx_t'(sched_cfg_pkg::NUM_RD - 1))
                        ? '0
                        : pop_idx + 1'b1;
                end
            end
        end
    end

    // burst register, only read in BURST after a pop has loaded it
    always_ff @(posedge clk) begin
        if (pop) begin
            burst_row_q <= pop_req.row;
            burst_grp_q <= pop_req.burst;
        end
    end

endmodule

`default_nettype wire

//--- rtl/bank_scheduler.sv
// per-bank dram request scheduler
// queues incoming requests and issues them read-first in same-row bursts
`timescale 1ns/1ns
`default_nettype none

module bank_scheduler (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        req_valid_i,
    input  wire  sched_req_pkg::req_t  req_i,
    input  wire                        issue_ready_i,
    output logic                       req_grant_o,
    output logic                       bus_req_o,
    output logic                       issue_valid_o,
    output sched_req_pkg::req_t        issue_req_o
);

    bank_if bank_bus ();                              // queue bank bus

    assign bank_bus.wr_req = req_i;                   // every queue sees the incoming entry

    queue_bank queue_bank_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .bank  (bank_bus.bank)
    );

    req_place req_place_inst (
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .grant_o     (req_grant_o),
        .bank        (bank_bus.place)
    );

    drain_ctrl drain_ctrl_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .issue_ready_i (issue_ready_i),
        .bus_req_o     (bus_req_o),
        .issue_valid_o (issue_valid_o),
        .issue_req_o   (issue_req_o),
        .bank          (bank_bus.ctrl)
    );

endmodule

`default_nettype wire

//--- bench/tb_bank_scheduler.sv
// bank scheduler testbench
// replays request batches from the data file and checks issue order, bursts and counts
`timescale 1ns/1ns
`default_nettype none

module tb_bank_scheduler;

    localparam int    CLK_PERIOD = 8;
    localparam int    RST_CYCLES = 16;
    localparam int    MAX_WORDS  = 256;
    localparam string DATA_FILE  = "bench/testdata_bank_sched.txt";
    localparam int    REQ_W      = sched_req_pkg::REQ_W;

    logic             clk;
    logic             rst_n;
    logic             req_valid_i;
    logic [REQ_W-1:0] req_i;
    logic             issue_ready_i;
    logic             req_grant_o;
    logic             bus_req_o;
    logic             issue_valid_o;
    logic [REQ_W-1:0] issue_req_o;

    logic [31:0]      prog [MAX_WORDS];           // op, argument and request per word
    logic [REQ_W-1:0] issued [$];                 // issues seen by the monitor, oldest first
    int               value_errors = 0;           // wrong values on a DUT output
    int               other_errors = 0;           // protocol or count failures
    int               cycles = 0;
    int               cycle_limit = 0;            // zero until the data file is loaded
    int               grants = 0;                 // per batch
    int               issues = 0;                 // per batch
    int               rises = 0;                  // bus_req_o rising edges per batch
    logic             bus_prev = 1'b0;
    logic             ready_seen = 1'b0;          // ready as taken at the last rising edge

    bank_scheduler bank_scheduler_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid_i   (req_valid_i),
        .req_i         (req_i),
        .issue_ready_i (issue_ready_i),
        .req_grant_o   (req_grant_o),
        .bus_req_o     (bus_req_o),
        .issue_valid_o (issue_valid_o),
        .issue_req_o   (issue_req_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // watchdog, limit set from the data length
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: no progress within %0d cycles", cycle_limit);
            $display("errors: %0d value mismatches, %0d other failures",
                     value_errors, other_errors);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    always @(posedge clk) begin
        ready_seen <= issue_ready_i;          // driven at the falling edge, stable here
    end

    // outputs are registered or depend on state only, stable at the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (issue_valid_o) begin
                issued.push_back(issue_req_o);
                issues = issues + 1;
            end
            if (bus_prev && ready_seen && !issue_valid_o) begin
                $display("no issue one cycle after a bus request met a ready bus");
                other_errors++;
            end
            if (!bus_prev && issue_valid_o) begin
                $display("request issued without a bus request in the cycle before");
                other_errors++;
            end
            if (bus_req_o && !bus_prev) begin
                rises = rises + 1;            // one per burst
            end
        end
        bus_prev = bus_req_o;
    end

    task automatic push_req(input logic [REQ_W-1:0] r);
        @(negedge clk);
        req_valid_i = 1'b1;
        req_i       = r;
        #1;
        while (!req_grant_o) begin            // source holds the request until granted
            @(negedge clk);
            #1;
        end
        grants = grants + 1;
        @(negedge clk);
        req_valid_i = 1'b0;
    endtask

    task automatic push_blocked(input logic [REQ_W-1:0] r, input int n);
        @(negedge clk);
        req_valid_i = 1'b1;
        req_i       = r;
        repeat (n) begin
            #1;
            if (req_grant_o !== 1'b0) begin   // queues of the kind are full
                $display("FAIL req_grant_o: expected %h got %h", 1'b0, req_grant_o);
                value_errors++;
            end
            @(negedge clk);
        end
        req_valid_i = 1'b0;                   // withdrawn, offered again after the drain
    endtask

    task automatic hold_ready_low(input int n);
        repeat (n) begin
            @(negedge clk);
            #1;
            if (bus_req_o !== 1'b1) begin
                $display("FAIL bus_req_o: expected %h got %h", 1'b1, bus_req_o);
                value_errors++;
            end
            if (issue_valid_o !== 1'b0) begin
                $display("FAIL issue_valid_o: expected %h got %h", 1'b0, issue_valid_o);
                value_errors++;
            end
        end
    endtask

    task automatic expect_issue(input logic [REQ_W-1:0] exp);
        logic [REQ_W-1:0] got;
        while (issued.size() == 0) begin
            @(negedge clk);
            #1;
        end
        got = issued.pop_front();
        if (got !== exp) begin
            $display("FAIL issue_req_o: expected %h got %h", exp, got);
            value_errors++;
        end
    endtask

    task automatic end_batch(input int exp_rises);
        repeat (6) @(negedge clk);            // let stray issues show up
        #1;
        if (issued.size() != 0) begin
            $display("%0d requests issued beyond the expected sequence", issued.size());
            other_errors++;
        end
        if (grants != issues) begin
            $display("%0d requests granted but %0d issued", grants, issues);
            other_errors++;
        end
        if (rises != exp_rises) begin
            $display("expected %0d bursts but saw %0d", exp_rises, rises);
            other_errors++;
        end
        repeat ($urandom % 8) @(negedge clk); // idle gap between batches
    endtask

    initial begin
        logic [31:0] word;
        int          n_words;
        int          pc;
        void'($urandom(32'h534b));
        rst_n         = 1'b0;
        req_valid_i   = 1'b0;
        req_i         = '0;
        issue_ready_i = 1'b0;
        for (int i = 0; i < MAX_WORDS; i++) begin
            prog[i] = 32'hF000_0000;          // end marker where the file stops
        end
        $readmemh(DATA_FILE, prog);
        n_words = 0;
        while (n_words < MAX_WORDS - 1 && prog[n_words][31:28] != 4'hF) begin
            n_words++;
        end
        cycle_limit = 40 * (n_words + 1) + 200;

        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // quiet after reset
        repeat (20) begin
            @(negedge clk);
            #1;
            if (bus_req_o !== 1'b0) begin
                $display("FAIL bus_req_o: expected %h got %h", 1'b0, bus_req_o);
                value_errors++;
            end
            if (issue_valid_o !== 1'b0) begin
                $display("FAIL issue_valid_o: expected %h got %h", 1'b0, issue_valid_o);
                value_errors++;
            end
        end

        for (pc = 0; pc < n_words; pc++) begin
            word = prog[pc];
            case (word[31:28])
                4'h0: begin                   // new batch, bus held off
                    @(negedge clk);
                    issue_ready_i = 1'b0;
                    #1;
                    grants = 0;
                    issues = 0;
                    rises  = 0;
                end
                4'h1: push_req(word[15:0]);
                4'h2: expect_issue(word[15:0]);
                4'h3: hold_ready_low(int'(word[27:16]));
                4'h4: push_blocked(word[15:0], int'(word[27:16]));
                4'h5: begin
                    @(negedge clk);
                    issue_ready_i = 1'b1;
                end
                4'h6: end_batch(int'(word[27:16]));
                default: begin
                    $display("unknown operation %h in the data file", word);
                    other_errors++;
                end
            endcase
        end

        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/testdata_bank_sched.txt
// word: op[31:28] arg[27:16] req[15:0], req = is_write row[4] burst[3] col[8]
// ops 0 batch start, 1 push, 2 expect issue, 3 hold ready low, 4 blocked push, 5 ready, 6 batch end
// read-first with a same-row burst spanning queue 0 and queue 2
00000000 10001910 1000A820 10003A30 10001940 10001950 10001951 10001952 1000A860 10004C70
50000000
20001910 20001940 20001950 20001951 20001952 20004C70 20003A30 2000A820 2000A860
60040000
// write drain down to the low watermark, then reads
00000000 10008801 10009002 10009803 10008904 10009105 10002006 10003007
50000000
20009002 20009803 20008801 20002006 20003007 20009105 20008904
60070000
// back-pressure on full write queues
00000000 10008811 10008812 10009013 10009014 10009815 10009816
300A0000 4005A017
50000000
20009013 20009014 20009815 20009816 20008811 20008812
1000A017 2000A017
60040000
F0000000

//--- src.f
rtl/sched_cfg_pkg.sv
rtl/sched_req_pkg.sv
rtl/bank_if.sv
rtl/req_array.sv
rtl/queue_bank.sv
rtl/req_place.sv
rtl/drain_ctrl.sv
rtl/bank_scheduler.sv
bench/tb_bank_scheduler.sv

//--- run_sim.sh
#!/bin/sh
# build and run the bank scheduler testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module tb_bank_scheduler -o sim_bank_scheduler \
    > build.log 2>&1 \
    && ./obj_dir/sim_bank_scheduler > sim.log 2>&1 \
    || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }

cat sim.log
grep -q "STATUS: FAIL" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "STATUS: PASS" sim.log || { echo "no pass status found"; exit 1; }
exit 0
